//--- design/img_pkg.sv
package img_pkg;

    // ==========================================================
    // Frame geometry
    // ==========================================================
    localparam int header_word_count = 8;
    localparam int frame_width       = 16;
    localparam int frame_height      = 8;

    // Header, pixel words, then the two checksum words
    localparam int img_word_count = header_word_count + frame_width * frame_height + 2;

    // ==========================================================
    // Frame store and FIFO sizing
    // ==========================================================
    localparam int block_depth      = 256;
    localparam int block_addr_w     = $clog2(block_depth);
    localparam int init_cycles      = 40;
    localparam int refresh_interval = 64;
    localparam int refresh_cycles   = 4;
    localparam int fifo_depth       = 16;
    localparam int fifo_ptr_w       = $clog2(fifo_depth);

    // ==========================================================
    // Word types
    // ==========================================================
    typedef logic [15:0]                      word_t;
    typedef logic [11:0]                      pixel_t;
    typedef logic [header_word_count*16-1:0]  header_t;
    typedef logic [0:0]                       block_t;
    typedef logic [7:0]                       word_count_t;
    typedef logic [17:0]                      stat_count_t;
    // Upper half sum2, lower half sum1
    typedef logic [31:0]                      checksum_t;

    typedef enum logic [1:0] {
        ram_none,
        ram_write,
        ram_read,
        ram_stop
    } ram_cmd_t;

endpackage

//--- design/fletcher_checksum.sv
module fletcher_checksum (
    input  logic               clk,
    input  logic               readout_rst,
    input  logic               clear,
    input  logic               en,
    input  img_pkg::word_t     din,
    output img_pkg::checksum_t dout
);
    import img_pkg::*;

    word_t sum1;
    word_t sum2;
    word_t sum1_next;
    word_t sum2_next;

    // Add modulo 65535 with one conditional subtract
    function automatic word_t mod_add(word_t a, word_t b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return (s >= 17'd65535) ? word_t'(s - 17'd65535) : s[15:0];
    endfunction

    always_comb begin
        sum1_next = mod_add(sum1, din);
        sum2_next = mod_add(sum2, sum1_next);
    end

    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (en) begin
            sum1 <= sum1_next;
            sum2 <= sum2_next;
        end
    end

    assign dout = {sum2, sum1};

endmodule

//--- design/word_fifo.sv
module word_fifo (
    input  logic           clk,
    input  logic           readout_rst,
    input  logic           flush,
    input  logic           push,
    input  img_pkg::word_t push_data,
    input  logic           pop,
    output img_pkg::word_t pop_data,
    output logic           not_empty
);
    import img_pkg::*;

    word_t                 mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w:0]   count;

    // ==========================================================
    // Storage
    // ==========================================================
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data  = mem[rd_ptr];
    assign not_empty = (count != '0);

    // ==========================================================
    // Pointers and fill level
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!readout_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The sensor side has no back-pressure, so the depth must cover refresh gaps
    a_no_overflow: assert property (@(posedge clk) disable iff (!readout_rst)
        push |-> (count < fifo_depth))
        else $error("word_fifo push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!readout_rst)
        pop |-> not_empty)
        else $error("word_fifo pop while empty");

endmodule

//--- design/frame_store.sv
module frame_store (
    input  logic              clk,
    input  logic              readout_rst,
    input  img_pkg::ram_cmd_t cmd,
    input  img_pkg::block_t   cmd_block,
    output logic              write_ready,
    input  logic              write_trigger,
    input  img_pkg::word_t    write_data,
    output logic              read_ready,
    input  logic              read_trigger,
    output img_pkg::word_t    read_data
);
    import img_pkg::*;

    word_t mem [2*block_depth];

    logic [block_addr_w:0] wr_addr [2];
    logic [block_addr_w:0] rd_addr [2];
    block_t                wr_block;
    block_t                rd_block;
    logic                  wr_open;
    logic                  rd_open;
    logic                  wr_fire;
    logic                  rd_fetch;

    logic [$clog2(init_cycles+1)-1:0]  init_cnt;
    logic [$clog2(refresh_interval)-1:0] refresh_cnt;
    logic                              init_done;
    logic                              refresh;

    // ==========================================================
    // Initialisation delay and refresh gaps
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            init_cnt    <= '0;
            refresh_cnt <= '0;
        end else begin
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
            end
            if (refresh_cnt == refresh_interval - 1) begin
                refresh_cnt <= '0;
            end else begin
                refresh_cnt <= refresh_cnt + 1'b1;
            end
        end
    end

    assign init_done = (init_cnt == init_cycles);
    assign refresh   = (refresh_cnt < refresh_cycles);

    assign write_ready = wr_open && init_done && !refresh;
    assign wr_fire     = write_ready && write_trigger;
    // Fetch the next word once the current one is taken
    assign rd_fetch    = rd_open && !read_ready && init_done && !refresh;

    // ==========================================================
    // Memory array
    // ==========================================================
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[{wr_block, wr_addr[wr_block][block_addr_w-1:0]}] <= write_data;
        end
        if (rd_fetch) begin
            read_data <= mem[{rd_block, rd_addr[rd_block][block_addr_w-1:0]}];
        end
    end

    // ==========================================================
    // Stream control
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            wr_open    <= 1'b0;
            rd_open    <= 1'b0;
            wr_block   <= '0;
            rd_block   <= '0;
            read_ready <= 1'b0;
            wr_addr    <= '{default: '0};
            rd_addr    <= '{default: '0};
        end else begin
            if (wr_fire) begin
                wr_addr[wr_block] <= wr_addr[wr_block] + 1'b1;
            end
            if (rd_fetch) begin
                rd_addr[rd_block] <= rd_addr[rd_block] + 1'b1;
                read_ready        <= 1'b1;
            end else if (read_ready && read_trigger) begin
                read_ready <= 1'b0;
            end

            // Commands override the stream updates above
            case (cmd)
                ram_write: begin
                    wr_open            <= 1'b1;
                    rd_open            <= 1'b0;
                    read_ready         <= 1'b0;
                    wr_block           <= cmd_block;
                    wr_addr[cmd_block] <= '0;
                end
                ram_read: begin
                    rd_open            <= 1'b1;
                    wr_open            <= 1'b0;
                    read_ready         <= 1'b0;
                    rd_block           <= cmd_block;
                    rd_addr[cmd_block] <= '0;
                end
                ram_stop: begin
                    rd_open    <= 1'b0;
                    read_ready <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    a_wr_in_block: assert property (@(posedge clk) disable iff (!readout_rst)
        wr_fire |-> (wr_addr[wr_block] < block_depth))
        else $error("frame_store write past end of block");

endmodule

//--- design/pixel_capture.sv
module pixel_capture (
    input  logic                 clk,
    input  logic                 readout_rst,
    input  logic                 start,
    input  img_pkg::header_t     header,
    input  img_pkg::pixel_t      img_d,
    input  logic                 img_fv,
    input  logic                 img_lv,
    output logic                 push,
    output img_pkg::word_t       push_data,
    output logic                 fifo_flush,
    output logic                 done,
    output img_pkg::word_count_t word_count,
    output img_pkg::stat_count_t highlight_count,
    output img_pkg::stat_count_t shadow_count
);
    import img_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_clear,
        st_settle,
        st_header,
        st_wait_fv_low,
        st_wait_fv_high,
        st_frame,
        st_sum_low,
        st_sum_high
    } state_t;

    state_t    state;
    pixel_t    d_q;
    logic      fv_q;
    logic      lv_q;
    logic      lv_prev;
    header_t   hdr_shift;
    logic [$clog2(header_word_count)-1:0] hdr_cnt;
    logic [1:0] col;
    logic [1:0] line;
    logic       stat_en;
    logic [6:0] stat_px;
    logic       sum_en;
    checksum_t  sum;

    // Checksum sees each word little endian
    fletcher_checksum u_checksum (
        .clk         (clk),
        .readout_rst (readout_rst),
        .clear       (fifo_flush),
        .en          (sum_en),
        .din         ({push_data[7:0], push_data[15:8]}),
        .dout        (sum)
    );

    assign fifo_flush = (state == st_clear);

    // ==========================================================
    // Sensor input register and sample position
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            lv_prev <= 1'b0;
            col     <= '0;
            line    <= '0;
        end else begin
            fv_q    <= img_fv;
            lv_q    <= img_lv;
            lv_prev <= lv_q;
            col     <= lv_q ? col + 1'b1 : 2'd0;
            if (!fv_q) begin
                line <= '0;
            end else if (lv_prev && !lv_q) begin
                line <= line + 1'b1;
            end
        end
    end

    // ==========================================================
    // Word data path
    // ==========================================================
    always_ff @(posedge clk) begin
        d_q     <= img_d;
        stat_px <= d_q[11:5];
        case (state)
            st_idle:     hdr_shift <= header;
            st_header: begin
                push_data <= hdr_shift[$bits(header_t)-1 -: 16];
                hdr_shift <= hdr_shift << 16;
            end
            st_frame:    push_data <= {d_q[7:0], 4'b0000, d_q[11:8]};
            st_sum_low:  push_data <= {sum[7:0], sum[15:8]};
            st_sum_high: push_data <= {sum[23:16], sum[31:24]};
            default: ;
        endcase
    end

    // ==========================================================
    // Capture FSM
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state           <= st_idle;
            push            <= 1'b0;
            sum_en          <= 1'b0;
            stat_en         <= 1'b0;
            done            <= 1'b0;
            hdr_cnt         <= '0;
            word_count      <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            push    <= 1'b0;
            sum_en  <= 1'b0;
            stat_en <= 1'b0;
            done    <= 1'b0;

            if (push) begin
                word_count <= word_count + 1'b1;
            end
            // Top seven bits decide highlight or shadow
            if (stat_en && (&stat_px)) begin
                highlight_count <= highlight_count + 1'b1;
            end else if (stat_en && !(|stat_px)) begin
                shadow_count <= shadow_count + 1'b1;
            end

            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_clear;
                    end
                end
                st_clear: begin
                    word_count      <= '0;
                    highlight_count <= '0;
                    shadow_count    <= '0;
                    hdr_cnt         <= '0;
                    state           <= st_settle;
                end
                st_settle: state <= st_header;
                st_header: begin
                    push    <= 1'b1;
                    sum_en  <= 1'b1;
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (hdr_cnt == header_word_count - 1) begin
                        state <= st_wait_fv_low;
                    end
                end
                st_wait_fv_low: begin
                    if (!fv_q) begin
                        state <= st_wait_fv_high;
                    end
                end
                st_wait_fv_high: begin
                    if (fv_q) begin
                        state <= st_frame;
                    end
                end
                st_frame: begin
                    push    <= fv_q && lv_q;
                    sum_en  <= fv_q && lv_q;
                    // First pixel of every fourth column and line
                    stat_en <= fv_q && lv_q && (col == 2'd0) && (line == 2'd0);
                    if (!fv_q) begin
                        state <= st_sum_low;
                    end
                end
                st_sum_low: begin
                    push  <= 1'b1;
                    state <= st_sum_high;
                end
                st_sum_high: begin
                    push  <= 1'b1;
                    done  <= 1'b1;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- design/img_controller.sv
module img_controller (
    input  logic                 clk,
    input  logic                 readout_rst,
    input  logic                 cmd_capture,
    input  logic                 cmd_readout,
    input  img_pkg::block_t      cmd_ram_block,
    input  img_pkg::header_t     cmd_header,
    input  img_pkg::pixel_t      img_d,
    input  logic                 img_fv,
    input  logic                 img_lv,
    output logic                 readout_flush,
    output logic                 readout_start,
    output logic                 readout_ready,
    input  logic                 readout_trigger,
    output img_pkg::word_t       readout_data,
    output logic                 capture_done,
    output img_pkg::word_count_t capture_word_count,
    output img_pkg::stat_count_t capture_highlight_count,
    output img_pkg::stat_count_t capture_shadow_count
);
    import img_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_cap_cmd,
        st_cap_wait_ready,
        st_cap_run,
        st_cap_drain,
        st_rd_cmd,
        st_rd_flush,
        st_rd_run
    } state_t;

    state_t      state;
    ram_cmd_t    ram_cmd;
    block_t      ram_block;
    logic        cap_start;
    logic        cap_done;
    logic        take;
    word_count_t read_count;

    logic        fifo_flush;
    logic        fifo_push;
    word_t       fifo_push_data;
    logic        fifo_pop;
    word_t       fifo_pop_data;
    logic        fifo_not_empty;
    logic        write_ready;

    // ==========================================================
    // Datapath blocks
    // ==========================================================
    pixel_capture u_pixel_capture (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .start           (cap_start),
        .header          (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .push            (fifo_push),
        .push_data       (fifo_push_data),
        .fifo_flush      (fifo_flush),
        .done            (cap_done),
        .word_count      (capture_word_count),
        .highlight_count (capture_highlight_count),
        .shadow_count    (capture_shadow_count)
    );

    word_fifo u_word_fifo (
        .clk         (clk),
        .readout_rst (readout_rst),
        .flush       (fifo_flush),
        .push        (fifo_push),
        .push_data   (fifo_push_data),
        .pop         (fifo_pop),
        .pop_data    (fifo_pop_data),
        .not_empty   (fifo_not_empty)
    );

    // A word moves when the store is ready and the FIFO holds one
    assign fifo_pop = write_ready && fifo_not_empty;

    frame_store u_frame_store (
        .clk           (clk),
        .readout_rst   (readout_rst),
        .cmd           (ram_cmd),
        .cmd_block     (ram_block),
        .write_ready   (write_ready),
        .write_trigger (fifo_not_empty),
        .write_data    (fifo_pop_data),
        .read_ready    (readout_ready),
        .read_trigger  (readout_trigger),
        .read_data     (readout_data)
    );

    // ==========================================================
    // Control FSM
    // ==========================================================
    assign take          = readout_ready && readout_trigger;
    assign readout_flush = (state == st_rd_cmd);
    assign readout_start = (state == st_rd_flush);

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state        <= st_idle;
            ram_cmd      <= ram_none;
            ram_block    <= '0;
            cap_start    <= 1'b0;
            capture_done <= 1'b0;
            read_count   <= '0;
        end else begin
            ram_cmd      <= ram_none;
            cap_start    <= 1'b0;
            capture_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_capture) begin
                        ram_block <= cmd_ram_block;
                        state     <= st_cap_cmd;
                    end else if (cmd_readout) begin
                        ram_block <= cmd_ram_block;
                        state     <= st_rd_cmd;
                    end
                end
                st_cap_cmd: begin
                    ram_cmd <= ram_write;
                    state   <= st_cap_wait_ready;
                end
                // Store may still be initialising, wait for the new stream
                st_cap_wait_ready: begin
                    if (ram_cmd == ram_none && write_ready) begin
                        cap_start <= 1'b1;
                        state     <= st_cap_run;
                    end
                end
                st_cap_run: begin
                    if (cap_done) begin
                        state <= st_cap_drain;
                    end
                end
                st_cap_drain: begin
                    if (!fifo_not_empty) begin
                        capture_done <= 1'b1;
                        state        <= st_idle;
                    end
                end
                st_rd_cmd: begin
                    ram_cmd    <= ram_read;
                    read_count <= '0;
                    state      <= st_rd_flush;
                end
                st_rd_flush: state <= st_rd_run;
                st_rd_run: begin
                    if (take) begin
                        read_count <= read_count + 1'b1;
                        // Stop before the store prefetches past the frame
                        if (read_count == img_word_count - 1) begin
                            ram_cmd <= ram_stop;
                            state   <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- bench/img_tb_checks.svh
// ============================================================
// Error reporting and compare tasks
// ============================================================
task automatic report_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_count(input string name, input word_count_t got, input word_count_t exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_stat(input string name, input stat_count_t got, input stat_count_t exp);
    if (got !== exp) begin
        report_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

// ============================================================
// Reference model of one frame
// ============================================================
function automatic word_t swap_bytes(input word_t w);
    return {w[7:0], w[15:8]};
endfunction

// Fills frame_px, the expected words of a block and the expected statistics
task automatic build_frame(input block_t blk, input header_t hdr, input logic [1:0] mode);
    int     i;
    int     line_i;
    int     col_i;
    int     idx;
    int     s1;
    int     s2;
    word_t  w;
    pixel_t p;
    s1            = 0;
    s2            = 0;
    idx           = 0;
    exp_highlight = '0;
    exp_shadow    = '0;
    // Header goes out most significant word first
    for (i = 0; i < header_word_count; i++) begin
        w                  = hdr[(header_word_count - 1 - i) * 16 +: 16];
        exp_mem[blk][idx]  = w;
        idx++;
        s1 = (s1 + swap_bytes(w)) % 65535;
        s2 = (s2 + s1) % 65535;
    end
    for (line_i = 0; line_i < frame_height; line_i++) begin
        for (col_i = 0; col_i < frame_width; col_i++) begin
            case (mode)
                mode_bright: p = 12'hfff;
                mode_dark:   p = 12'h000;
                default:     p = pixel_t'($random(seed));
            endcase
            frame_px[line_i * frame_width + col_i] = p;
            // Low byte of the sample first, top nibble zero padded
            w                 = {p[7:0], 4'h0, p[11:8]};
            exp_mem[blk][idx] = w;
            idx++;
            s1 = (s1 + swap_bytes(w)) % 65535;
            s2 = (s2 + s1) % 65535;
            if ((line_i % 4 == 0) && (col_i % 4 == 0)) begin
                if (p[11:5] == 7'h7f) begin
                    exp_highlight = exp_highlight + 1'b1;
                end else if (p[11:5] == 7'h00) begin
                    exp_shadow = exp_shadow + 1'b1;
                end
            end
        end
    end
    // sum1 then sum2, each byte swapped
    exp_mem[blk][idx]     = swap_bytes(word_t'(s1));
    exp_mem[blk][idx + 1] = swap_bytes(word_t'(s2));
endtask

//--- bench/img_controller_tb.sv
module img_controller_tb;
    import img_pkg::*;

    localparam logic [1:0] mode_random = 2'd0;
    localparam logic [1:0] mode_bright = 2'd1;
    localparam logic [1:0] mode_dark   = 2'd2;

    localparam int step_count        = 7;
    localparam int fv_low_cycles     = 100;
    localparam int capture_timeout   = 4000;
    localparam int word_timeout      = 64;
    localparam int idle_check_cycles = 16;

    localparam header_t hdr_a = 128'h4849_4d47_0000_0001_0010_0008_a5a5_5a5a;
    localparam header_t hdr_b = 128'h4849_4d47_0000_0002_ffff_0000_1234_8001;
    localparam header_t hdr_c = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;

    typedef struct packed {
        logic       is_read;
        block_t     blk;
        logic [1:0] mode;
        header_t    hdr;
    } step_t;

    logic        clk = 1'b0;
    logic        readout_rst;
    logic        cmd_capture;
    logic        cmd_readout;
    block_t      cmd_ram_block;
    header_t     cmd_header;
    pixel_t      img_d;
    logic        img_fv;
    logic        img_lv;
    logic        readout_flush;
    logic        readout_start;
    logic        readout_ready;
    logic        readout_trigger;
    word_t       readout_data;
    logic        capture_done;
    word_count_t capture_word_count;
    stat_count_t capture_highlight_count;
    stat_count_t capture_shadow_count;

    integer      seed = 32'h126f_06bb;
    word_t       exp_mem [2][img_word_count];
    pixel_t      frame_px [frame_width * frame_height];
    stat_count_t exp_highlight;
    stat_count_t exp_shadow;
    int          cap_pulses = 0;
    int          flush_pulses = 0;
    int          start_pulses = 0;

    // Both blocks written, read back in either order, block 0 rewritten
    step_t steps [step_count] = '{
        {1'b0, 1'b0, mode_random, hdr_a},
        {1'b0, 1'b1, mode_bright, hdr_b},
        {1'b1, 1'b0, mode_random, hdr_a},
        {1'b1, 1'b1, mode_random, hdr_a},
        {1'b0, 1'b0, mode_dark,   hdr_c},
        {1'b1, 1'b1, mode_random, hdr_a},
        {1'b1, 1'b0, mode_random, hdr_a}
    };

    `include "img_tb_checks.svh"

    img_controller u_dut (
        .clk                     (clk),
        .readout_rst             (readout_rst),
        .cmd_capture             (cmd_capture),
        .cmd_readout             (cmd_readout),
        .cmd_ram_block           (cmd_ram_block),
        .cmd_header              (cmd_header),
        .img_d                   (img_d),
        .img_fv                  (img_fv),
        .img_lv                  (img_lv),
        .readout_flush           (readout_flush),
        .readout_start           (readout_start),
        .readout_ready           (readout_ready),
        .readout_trigger         (readout_trigger),
        .readout_data            (readout_data),
        .capture_done            (capture_done),
        .capture_word_count      (capture_word_count),
        .capture_highlight_count (capture_highlight_count),
        .capture_shadow_count    (capture_shadow_count)
    );

    always #10 clk = ~clk;

    // Output pulse counter, one count per high cycle
    always @(negedge clk) begin
        if (readout_rst === 1'b1) begin
            if (capture_done) begin
                cap_pulses++;
            end
            if (readout_flush) begin
                flush_pulses++;
            end
            if (readout_start) begin
                start_pulses++;
            end
        end
    end

    task automatic check_idle_outputs();
        check_flag("capture_done", capture_done, 1'b0);
        check_flag("readout_flush", readout_flush, 1'b0);
        check_flag("readout_start", readout_start, 1'b0);
        check_flag("readout_ready", readout_ready, 1'b0);
        check_count("capture_word_count", capture_word_count, '0);
        check_stat("capture_highlight_count", capture_highlight_count, '0);
        check_stat("capture_shadow_count", capture_shadow_count, '0);
    endtask

    // ==========================================================
    // Sensor frame generator
    // ==========================================================
    task automatic drive_frame();
        int line_i;
        int col_i;
        img_fv <= 1'b1;
        img_lv <= 1'b0;
        repeat (3) @(posedge clk);
        for (line_i = 0; line_i < frame_height; line_i++) begin
            for (col_i = 0; col_i < frame_width; col_i++) begin
                img_lv <= 1'b1;
                img_d  <= frame_px[line_i * frame_width + col_i];
                @(posedge clk);
            end
            // Line blanking
            img_lv <= 1'b0;
            repeat (3) @(posedge clk);
        end
        img_fv <= 1'b0;
    endtask

    task automatic run_capture(input block_t blk, input header_t hdr, input logic [1:0] mode);
        int waited;
        build_frame(blk, hdr, mode);
        @(posedge clk);
        cmd_capture   <= 1'b1;
        cmd_ram_block <= blk;
        cmd_header    <= hdr;
        @(posedge clk);
        cmd_capture <= 1'b0;
        // Frame gap long enough for the store init and the header
        repeat (fv_low_cycles) @(posedge clk);
        drive_frame();
        waited = 0;
        @(negedge clk);
        while (!capture_done) begin
            waited++;
            if (waited > capture_timeout) begin
                report_failure("timeout: capture_done never pulsed after the frame");
            end
            @(negedge clk);
        end
        check_count("capture_word_count", capture_word_count, word_count_t'(img_word_count));
        check_stat("capture_highlight_count", capture_highlight_count, exp_highlight);
        check_stat("capture_shadow_count", capture_shadow_count, exp_shadow);
    endtask

    // ==========================================================
    // Readout consumer with random back-pressure
    // ==========================================================
    task automatic run_readout(input block_t blk);
        int taken;
        int waited;
        @(posedge clk);
        cmd_readout   <= 1'b1;
        cmd_ram_block <= blk;
        @(posedge clk);
        cmd_readout <= 1'b0;
        @(negedge clk);
        check_flag("readout_flush", readout_flush, 1'b1);
        check_flag("readout_start", readout_start, 1'b0);
        @(negedge clk);
        check_flag("readout_flush", readout_flush, 1'b0);
        check_flag("readout_start", readout_start, 1'b1);
        taken  = 0;
        waited = 0;
        while (taken < img_word_count) begin
            @(posedge clk);
            readout_trigger <= (($random(seed) & 32'h3) != 0);
            @(negedge clk);
            // Word is taken at the coming rising edge
            if (readout_ready && readout_trigger) begin
                check_word($sformatf("readout_data[%0d]", taken), readout_data,
                           exp_mem[blk][taken]);
                taken++;
                waited = 0;
            end else begin
                waited++;
                if (waited > word_timeout) begin
                    report_failure($sformatf("timeout: readout word %0d never became ready",
                                             taken));
                end
            end
        end
        // Keep pulling, nothing more may appear
        @(posedge clk);
        readout_trigger <= 1'b1;
        repeat (idle_check_cycles) begin
            @(negedge clk);
            check_flag("readout_ready", readout_ready, 1'b0);
        end
        @(posedge clk);
        readout_trigger <= 1'b0;
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        int s;
        int exp_cap;
        int exp_rd;
        readout_rst     = 1'b0;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_ram_block   = '0;
        cmd_header      = '0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        exp_cap         = 0;
        exp_rd          = 0;

        repeat (4) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        readout_rst <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end

        // First capture starts while the store is still initialising
        for (s = 0; s < step_count; s++) begin
            if (steps[s].is_read) begin
                run_readout(steps[s].blk);
                exp_rd++;
            end else begin
                run_capture(steps[s].blk, steps[s].hdr, steps[s].mode);
                exp_cap++;
            end
            @(posedge clk);
            check_count("capture_done pulses", word_count_t'(cap_pulses), word_count_t'(exp_cap));
            check_count("readout_flush pulses", word_count_t'(flush_pulses),
                        word_count_t'(exp_rd));
            check_count("readout_start pulses", word_count_t'(start_pulses),
                        word_count_t'(exp_rd));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- img_capture.f
+incdir+bench
design/img_pkg.sv
design/fletcher_checksum.sv
design/word_fifo.sv
design/frame_store.sv
design/pixel_capture.sv
design/img_controller.sv
bench/img_controller_tb.sv
